// File: hw/dcache_consts.svh
// data cache geometry and memory interface widths
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ------------------------------------------------------------
// processor side
// ------------------------------------------------------------
`define DC_WORD_W  32
`define DC_ADDR_W  30 // word address

// ------------------------------------------------------------
// cache geometry
// ------------------------------------------------------------
`define DC_LINE_W  128
`define DC_WAYS    2
`define DC_SETS    4
`define DC_IDX_W   2
`define DC_OFS_W   2 // word within line
`define DC_TAG_W   26

// ------------------------------------------------------------
// slow memory side
// ------------------------------------------------------------
`define DC_MADDR_W 28 // line address

`endif

// File: hw/dcache_pkg.sv
// request, cache entry and state types shared by the data cache blocks
`include "dcache_consts.svh"

package dcache_pkg;

	// word request from the processor, held while stalled
	typedef struct packed {
		logic                  read;
		logic                  write;
		logic [`DC_ADDR_W-1:0] addr;  // word address
		logic [`DC_WORD_W-1:0] wdata;
	} proc_req_t;

	// line request to slow memory, held until mem_ready
	typedef struct packed {
		logic                   read;
		logic                   write;
		logic [`DC_MADDR_W-1:0] addr;  // line address
		logic [`DC_LINE_W-1:0]  wdata;
	} mem_req_t;

	// one way of one set
	typedef struct packed {
		logic                  valid;
		logic                  dirty;
		logic [`DC_TAG_W-1:0]  tag;
		logic [`DC_LINE_W-1:0] data;
	} entry_t;

	// store update requested by the controller
	typedef enum logic [1:0] {
		OP_NONE       = 2'd0,
		OP_WRITE_WORD = 2'd1, // merge word into hit way
		OP_FILL       = 2'd2, // refill victim way
		OP_CLEAN      = 2'd3  // victim written back
	} store_op_e;

	typedef enum logic [1:0] {
		ST_IDLE       = 2'd0,
		ST_COMPARE    = 2'd1,
		ST_WRITE_BACK = 2'd2,
		ST_ALLOCATE   = 2'd3
	} ctrl_state_e;

endpackage

// File: hw/dcache_store.sv
// way arrays, fill-order victim bits, hit detection and line updates of the data cache
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_store (
	input  logic                  clk,
	input  logic                  proc_reset,
	input  dcache_pkg::proc_req_t req,
	input  dcache_pkg::store_op_e op,
	input  logic [`DC_LINE_W-1:0] fill_line,
	output logic                  hit,
	output logic                  victim_dirty,
	output logic [`DC_TAG_W-1:0]  victim_tag,
	output logic [`DC_LINE_W-1:0] victim_line,
	output logic [`DC_WORD_W-1:0] rd_word
);
	localparam int WAY_W = $clog2(`DC_WAYS);

	dcache_pkg::entry_t ways_q [`DC_WAYS][`DC_SETS];
	logic [`DC_SETS-1:0] victim_q; // one bit per set, way to refill next

	logic [`DC_OFS_W-1:0] ofs;
	logic [`DC_IDX_W-1:0] idx;
	logic [`DC_TAG_W-1:0] tag;
	logic [`DC_WAYS-1:0]  hit_vec;
	logic [WAY_W-1:0]     hit_way;
	logic [WAY_W-1:0]     vic_way;
	dcache_pkg::entry_t   hit_ent;
	dcache_pkg::entry_t   vic_ent;

	// word address = {tag, index, offset}
	assign ofs = req.addr[`DC_OFS_W-1:0];
	assign idx = req.addr[`DC_OFS_W +: `DC_IDX_W];
	assign tag = req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];

	// ------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			hit_vec[w] = ways_q[w][idx].valid && (ways_q[w][idx].tag == tag);
			if (hit_vec[w])
				hit_way = WAY_W'(w);
		end
	end

	assign hit     = (req.read | req.write) & (|hit_vec);
	assign hit_ent = ways_q[hit_way][idx];
	assign rd_word = hit_ent.data[ofs*`DC_WORD_W +: `DC_WORD_W]; // addressed word

	// victim side, used by write-back and refill
	assign vic_way      = WAY_W'(victim_q[idx]);
	assign vic_ent      = ways_q[vic_way][idx];
	assign victim_dirty = vic_ent.valid & vic_ent.dirty;
	assign victim_tag   = vic_ent.tag;
	assign victim_line  = vic_ent.data;

	// ------------------------------------------------------------
	// updates
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				for (int w = 0; w < `DC_WAYS; w++) begin
					ways_q[w][s].valid <= 1'b0;
					ways_q[w][s].dirty <= 1'b0;
				end
			end
			victim_q <= '0; // way 0 refills first
		end else begin
			case (op)
				dcache_pkg::OP_WRITE_WORD: begin
					ways_q[hit_way][idx].data[ofs*`DC_WORD_W +: `DC_WORD_W] <= req.wdata;
					ways_q[hit_way][idx].dirty <= 1'b1;
				end
				dcache_pkg::OP_FILL: begin
					ways_q[vic_way][idx].valid <= 1'b1;
					ways_q[vic_way][idx].dirty <= 1'b0; // fresh from memory
					ways_q[vic_way][idx].tag   <= tag;
					ways_q[vic_way][idx].data  <= fill_line;
					// only a fill moves the pointer, so order is fill order
					victim_q[idx] <= ~victim_q[idx];
				end
				dcache_pkg::OP_CLEAN: begin
					ways_q[vic_way][idx].dirty <= 1'b0;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// File: hw/dcache_ctrl.sv
// miss handling FSM of the data cache, drives the slow memory request and the stall
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl (
	input  logic                  clk,
	input  logic                  proc_reset,
	input  dcache_pkg::proc_req_t req,
	input  logic                  hit,
	input  logic                  victim_dirty,
	input  logic [`DC_TAG_W-1:0]  victim_tag,
	input  logic [`DC_LINE_W-1:0] victim_line,
	input  logic                  mem_ready,
	output dcache_pkg::mem_req_t  mem_req,
	output dcache_pkg::store_op_e op,
	output logic                  proc_stall
);
	dcache_pkg::ctrl_state_e state_q;
	dcache_pkg::ctrl_state_e state_d;

	logic                 access;
	logic [`DC_IDX_W-1:0] idx;

	assign access = req.read | req.write;
	assign idx    = req.addr[`DC_OFS_W +: `DC_IDX_W];

	// ------------------------------------------------------------
	// state register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset)
			state_q <= dcache_pkg::ST_IDLE;
		else
			state_q <= state_d;
	end

	// ------------------------------------------------------------
	// next state and outputs
	// ------------------------------------------------------------
	always_comb begin
		state_d    = state_q;
		op         = dcache_pkg::OP_NONE;
		proc_stall = 1'b1;
		mem_req    = '0;

		case (state_q)
			dcache_pkg::ST_IDLE: begin
				state_d = dcache_pkg::ST_COMPARE; // one stalled cycle after reset
			end

			dcache_pkg::ST_COMPARE: begin
				if (access && !hit) begin
					// miss, dirty victim goes out first
					if (victim_dirty)
						state_d = dcache_pkg::ST_WRITE_BACK;
					else
						state_d = dcache_pkg::ST_ALLOCATE;
				end else begin
					proc_stall = 1'b0; // hit or no request
					if (req.write && hit)
						op = dcache_pkg::OP_WRITE_WORD;
				end
			end

			dcache_pkg::ST_WRITE_BACK: begin
				mem_req.write = !mem_ready; // dropped in the ready cycle
				mem_req.addr  = {victim_tag, idx}; // victim's own line address
				mem_req.wdata = victim_line;
				if (mem_ready) begin
					op      = dcache_pkg::OP_CLEAN;
					state_d = dcache_pkg::ST_ALLOCATE;
				end
			end

			dcache_pkg::ST_ALLOCATE: begin
				mem_req.read = !mem_ready;
				mem_req.addr = req.addr[`DC_ADDR_W-1 -: `DC_MADDR_W];
				if (mem_ready) begin
					// line is in mem_rdata this cycle
					op      = dcache_pkg::OP_FILL;
					state_d = dcache_pkg::ST_COMPARE;
				end
			end

			default: begin
				state_d = dcache_pkg::ST_IDLE;
			end
		endcase
	end

endmodule

// File: hw/dcache_top.sv
// 2-way write-back data cache between a word processor port and a line-wide slow memory
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top (
	input  logic                  clk,
	input  logic                  proc_reset,
	input  dcache_pkg::proc_req_t proc_req,
	output logic [`DC_WORD_W-1:0] proc_rdata,
	output logic                  proc_stall,
	output dcache_pkg::mem_req_t  mem_req,
	input  logic [`DC_LINE_W-1:0] mem_rdata,
	input  logic                  mem_ready
);
	dcache_pkg::store_op_e  op;
	logic                   hit;
	logic                   victim_dirty;
	logic [`DC_TAG_W-1:0]   victim_tag;
	logic [`DC_LINE_W-1:0]  victim_line;

	dcache_ctrl ctrl_i (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.req          (proc_req),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_line  (victim_line),
		.mem_ready    (mem_ready),
		.mem_req      (mem_req),
		.op           (op),
		.proc_stall   (proc_stall)
	);

	// refill data comes straight from memory
	dcache_store store_i (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.req          (proc_req),
		.op           (op),
		.fill_line    (mem_rdata),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_line  (victim_line),
		.rd_word      (proc_rdata)
	);

endmodule

// File: dv/dcache_chk.sv
// handshake assertions for the data cache top level
`timescale 1ns/1ps

module dcache_chk (
	input logic                 clk,
	input logic                 proc_reset,
	input logic                 proc_stall,
	input dcache_pkg::mem_req_t mem_req,
	input logic                 mem_ready
);
	int fail_cnt = 0; // failed assertions so far

	// ------------------------------------------------------------
	// memory side
	// ------------------------------------------------------------
	no_read_and_write: assert property (
		@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write)
	) else begin
		$error("memory read and write high together");
		fail_cnt++;
	end

	// request held without ready keeps its address
	addr_held: assert property (
		@(posedge clk) disable iff (proc_reset)
		(mem_req.read || mem_req.write) && !mem_ready |=> $stable(mem_req.addr)
	) else begin
		$error("memory address changed while request was pending");
		fail_cnt++;
	end

	// ------------------------------------------------------------
	// processor side
	// ------------------------------------------------------------
	stall_after_reset: assert property (
		@(posedge clk) $fell(proc_reset) |-> proc_stall
	) else begin
		$error("no stall in the cycle after reset");
		fail_cnt++;
	end

endmodule

bind dcache_top dcache_chk chk_i (
	.clk        (clk),
	.proc_reset (proc_reset),
	.proc_stall (proc_stall),
	.mem_req    (mem_req),
	.mem_ready  (mem_ready)
);

// File: dv/dcache_tb.sv
// file-driven testbench for the data cache with a random-latency slow memory model
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tb;
	localparam logic [31:0] MEM_KEY = 32'h5a5a_0000;
	localparam logic [27:0] NO_WB   = 28'hfff_ffff;

	logic                  clk;
	logic                  proc_reset;
	dcache_pkg::proc_req_t proc_req;
	logic [`DC_WORD_W-1:0] proc_rdata;
	logic                  proc_stall;
	dcache_pkg::mem_req_t  mem_req;
	logic [`DC_LINE_W-1:0] mem_rdata;
	logic                  mem_ready;

	logic [`DC_LINE_W-1:0] mem_line [256];  // slow memory contents
	logic [`DC_WORD_W-1:0] golden [1024];   // expected word values
	byte                   t_op [$];
	logic [29:0]           t_addr [$];
	logic [31:0]           t_wdata [$];
	logic [31:0]           t_exp [$];
	int                    t_nreq [$];
	logic [27:0]           t_wb [$];
	int                    n_tests = 0;
	int                    errors = 0;
	int                    test_errs;
	int                    req_seen;
	logic [27:0]           cur_line;
	logic [27:0]           cur_wb;
	dcache_pkg::mem_req_t  lat;
	logic                  busy;
	logic [1:0]            wait_cnt;

	dcache_top dcache_top_i (.*);

	always #10 clk = ~clk;

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_word(input logic [`DC_WORD_W-1:0] got, exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s read %h expected %h", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_mem(input dcache_pkg::mem_req_t got, exp, input string what);
		if (got !== exp) begin
			$display({"MISMATCH at %0t: %s rd %b wr %b addr %h data %h,",
				" expected rd %b wr %b addr %h data %h"},
				$time, what, got.read, got.write, got.addr, got.wdata,
				exp.read, exp.write, exp.addr, exp.wdata);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_stall(input logic got, exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s stall %b expected %b", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	function automatic logic [`DC_LINE_W-1:0] golden_line(input logic [27:0] la);
		logic [`DC_LINE_W-1:0] l;
		for (int i = 0; i < 4; i++)
			l[i*32 +: 32] = golden[int'(la[7:0]) * 4 + i];
		return l;
	endfunction

	// a dirty victim goes out before the refill read
	task automatic expect_request(input dcache_pkg::mem_req_t got);
		dcache_pkg::mem_req_t exp;
		exp = '0;
		if (cur_wb != NO_WB && req_seen == 0) begin
			exp.write = 1'b1;
			exp.addr  = cur_wb;
			exp.wdata = golden_line(cur_wb);
		end else begin
			exp.read = 1'b1;
			exp.addr = cur_line;
		end
		check_mem(got, exp, "memory request");
		req_seen++;
	endtask

	// ------------------------------------------------------------
	// slow memory, one ready pulse per request after 1 to 4 cycles
	// ------------------------------------------------------------
	always @(posedge clk) begin
		if (proc_reset) begin
			mem_ready <= 1'b0;
			busy      <= 1'b0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0;
		end else if (busy) begin
			if (wait_cnt == 2'd0) begin
				mem_ready <= 1'b1;
				mem_rdata <= mem_line[lat.addr[7:0]];
				if (lat.write)
					mem_line[lat.addr[7:0]] <= lat.wdata;
				busy <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end else if (mem_req.read || mem_req.write) begin
			lat      <= mem_req;
			busy     <= 1'b1;
			wait_cnt <= 2'($urandom % 4);
			expect_request(mem_req);
		end
	end

	// watchdog sized from the test count
	initial begin
		wait (n_tests > 0);
		repeat (n_tests * 200) @(posedge clk);
		$display("timeout: cache did not finish the tests in time");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		int    fd;
		string line;
		byte   opc;
		logic [31:0] a, wd, ex, wb;
		int    nr;
		void'($urandom(32'he252_ae66));
		clk        = 1'b0;
		proc_reset = 1'b1;
		proc_req   = '0;
		mem_rdata  = '0;
		mem_ready  = 1'b0;
		busy       = 1'b0;
		wait_cnt   = 2'd0;
		lat        = '0;
		cur_line   = '0;
		cur_wb     = NO_WB;
		req_seen   = 0;
		test_errs  = 0;
		for (int w = 0; w < 1024; w++)
			golden[w] = 32'(w) ^ MEM_KEY;  // word address xor key
		for (int l = 0; l < 256; l++)
			mem_line[l] = golden_line(28'(l));

		fd = $fopen("dv/dcache_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open the test file dv/dcache_tests.txt");
			$display("ERRORS FOUND");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				void'($fgets(line, fd));
				if (line.len() > 3 && line[0] != "#" &&
				    $sscanf(line, "%c %h %h %h %d %h", opc, a, wd, ex, nr, wb) == 6) begin
					t_op.push_back(opc);
					t_addr.push_back(a[29:0]);
					t_wdata.push_back(wd);
					t_exp.push_back(ex);
					t_nreq.push_back(nr);
					t_wb.push_back(wb[27:0]);
				end
			end
			$fclose(fd);
			n_tests = t_op.size();
			if (n_tests == 0) begin
				$display("no tests could be read from dv/dcache_tests.txt");
				errors++;
			end

			repeat (4) @(posedge clk);
			proc_reset <= 1'b0;

			// ------------------------------------------------------------
			// one request per test, completes when stall drops
			// ------------------------------------------------------------
			for (int i = 0; i < n_tests; i++) begin
				test_errs = 0;
				req_seen  = 0;
				cur_line  = t_addr[i][29:2];
				cur_wb    = t_wb[i];
				@(posedge clk);
				proc_req <= {t_op[i] == "R", t_op[i] == "W", t_addr[i], t_wdata[i]};
				@(negedge clk);
				if (t_nreq[i] == 0) // a hit completes in its first cycle
					check_stall(proc_stall, 1'b0, $sformatf("test %0d", i));
				while (proc_stall)
					@(negedge clk);
				if (t_op[i] == "R")
					check_word(proc_rdata, t_exp[i], $sformatf("test %0d", i));
				else
					golden[t_addr[i][9:0]] = t_wdata[i];
				if (req_seen != t_nreq[i]) begin
					$display("MISMATCH at %0t: test %0d made %0d memory requests, expected %0d",
						$time, i, req_seen, t_nreq[i]);
					errors++;
					test_errs++;
				end
				$display("test %0d %c %h: %s", i, t_op[i], t_addr[i],
					test_errs == 0 ? "ok" : "failed");
			end
			@(posedge clk);
			proc_req <= '0;
			@(posedge clk);

			errors += dcache_top_i.chk_i.fail_cnt;
			$display("%0d tests run, %0d errors", n_tests, errors);
			if (errors == 0)
				$display("NO ERRORS");
			else
				$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

// File: dv/dcache_tests.txt
# op  word_addr  wdata     expected  mem_reqs  writeback_line (fffffff = none)
# R reads and checks expected, W writes wdata (expected column unused)
R 000 00000000 5a5a0000 1 fffffff
R 001 00000000 5a5a0001 0 fffffff
W 002 11112222 00000000 0 fffffff
R 002 00000000 11112222 0 fffffff
R 010 00000000 5a5a0010 1 fffffff
R 020 00000000 5a5a0020 2 0000000
R 011 00000000 5a5a0011 0 fffffff
R 002 00000000 11112222 1 fffffff
R 003 00000000 5a5a0003 0 fffffff
W 024 cafe0001 00000000 1 fffffff
R 024 00000000 cafe0001 0 fffffff
R 025 00000000 5a5a0025 0 fffffff
R 027 00000000 5a5a0027 0 fffffff
W 008 aaaa0008 00000000 1 fffffff
W 019 bbbb0019 00000000 1 fffffff
R 028 00000000 5a5a0028 2 0000002
R 02b 00000000 5a5a002b 0 fffffff
R 01a 00000000 5a5a001a 0 fffffff
R 038 00000000 5a5a0038 2 0000006
R 019 00000000 bbbb0019 1 fffffff
R 008 00000000 aaaa0008 1 fffffff
R 000 00000000 5a5a0000 0 fffffff
R 012 00000000 5a5a0012 1 fffffff
W 03c 12345678 00000000 1 fffffff
R 03c 00000000 12345678 0 fffffff
R 07c 00000000 5a5a007c 1 fffffff
R 0bc 00000000 5a5a00bc 2 000000f
R 03c 00000000 12345678 1 fffffff

// File: flist.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_store.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
dv/dcache_chk.sv
dv/dcache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module dcache_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vdcache_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1
